// ==== common/icache_cfg.svh ====
// ------------------------------
// icache configuration
// geometry and address widths
// ------------------------------

`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ------------------------------
// geometry
// ------------------------------

// 2-way, 16 sets
`define ICACHE_ASSOC 2
`define ICACHE_NUM_SETS 16
`define ICACHE_INDEX_WIDTH 4
`define ICACHE_WAY_WIDTH 1

// 16B fetch out of a 32B block
`define ICACHE_FETCH_BYTES 16
`define ICACHE_FETCH_BITS (`ICACHE_FETCH_BYTES * 8)
`define ICACHE_BLKOFF_WIDTH 1
`define ICACHE_BLOCK_BITS (`ICACHE_FETCH_BITS * (2 ** `ICACHE_BLKOFF_WIDTH))

// ------------------------------
// addresses
// ------------------------------

`define ICACHE_TAG_WIDTH 10

// block address toward L2 is tag above index
`define BLOCK_ADDR_WIDTH (`ICACHE_TAG_WIDTH + `ICACHE_INDEX_WIDTH)

`endif

// ==== common/addr_pkg.sv ====
// ------------------------------
// address formats for the icache
// ------------------------------

`include "icache_cfg.svh"

package addr_pkg;

    // block address split into its fields
    typedef struct packed {
        logic [`ICACHE_TAG_WIDTH-1:0]   tag;
        logic [`ICACHE_INDEX_WIDTH-1:0] index;
    } block_addr_fields_t;

    // L2 block address, seen flat on the ports and split inside the cache
    typedef union packed {
        logic [`BLOCK_ADDR_WIDTH-1:0] flat;
        block_addr_fields_t           fields;
    } block_addr_t;

    // data array row, one fetch chunk of one set
    typedef struct packed {
        logic [`ICACHE_INDEX_WIDTH-1:0]  index;
        logic [`ICACHE_BLKOFF_WIDTH-1:0] blkoff;
    } fetch_addr_t;

endpackage

// ==== common/icache_pkg.sv ====
// ------------------------------
// icache array contents and
// miss register state
// ------------------------------

`include "icache_cfg.svh"

package icache_pkg;

    typedef struct packed {
        logic                         valid;
        logic [`ICACHE_TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    // one entry per way, as the tag array stores a set
    typedef tag_entry_t [`ICACHE_ASSOC-1:0] tag_set_t;

    typedef logic [`ICACHE_ASSOC-1:0][`ICACHE_FETCH_BITS-1:0] fetch_set_t;

    // whole block, chunk 0 in the low bits
    typedef logic [(2**`ICACHE_BLKOFF_WIDTH)-1:0][`ICACHE_FETCH_BITS-1:0] block_buf_t;

    // control fields of the miss register
    typedef struct packed {
        logic                            valid;
        logic                            requested;
        logic [`ICACHE_INDEX_WIDTH-1:0]  index;
        logic [`ICACHE_TAG_WIDTH-1:0]    tag;
        logic [`ICACHE_WAY_WIDTH-1:0]    way;
        logic                            data_valid;
        logic [`ICACHE_BLKOFF_WIDTH-1:0] blkoff;
        logic                            delay;
    } miss_ctrl_t;

    // fill state seen by the response stage for bypass
    typedef struct packed {
        logic                           active;
        logic [`ICACHE_INDEX_WIDTH-1:0] index;
        logic [`ICACHE_TAG_WIDTH-1:0]   tag;
        logic [`ICACHE_WAY_WIDTH-1:0]   way;
        block_buf_t                     buffer;
    } fill_t;

endpackage

// ==== logic/bram_1r1w.sv ====
// ------------------------------
// 1R1W memory, registered read,
// write enable per lane
// ------------------------------

module bram_1r1w #(
    parameter int LANE_BITS = 8,
    parameter int LANES = 1,
    parameter int DEPTH = 16
) (
    input  logic                              CLK,
    input  logic                              nRST,

    input  logic                              ren,
    input  logic [$clog2(DEPTH)-1:0]          rindex,
    output logic [LANES-1:0][LANE_BITS-1:0]   rdata,

    input  logic [LANES-1:0]                  wen,
    input  logic [$clog2(DEPTH)-1:0]          windex,
    input  logic [LANES-1:0][LANE_BITS-1:0]   wdata
);

    logic [LANES-1:0][LANE_BITS-1:0] mem [DEPTH];

    // contents come up cleared so valid bits start at zero
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            // read sees the old contents on a same-row write
            if (ren) begin
                rdata <= mem[rindex];
            end
            for (int lane = 0; lane < LANES; lane++) begin
                if (wen[lane]) begin
                    mem[windex][lane] <= wdata[lane];
                end
            end
        end
    end

endmodule

// ==== logic/way_plru.sv ====
// ------------------------------
// per-set PLRU bits and victim
// way choice
// ------------------------------

`include "icache_cfg.svh"

module way_plru (
    input  logic                           CLK,
    input  logic                           nRST,

    // hit feedback
    input  logic                           touch_valid,
    input  logic [`ICACHE_INDEX_WIDTH-1:0] touch_index,
    input  logic [`ICACHE_WAY_WIDTH-1:0]   touch_way,

    // victim lookup for a miss
    input  logic [`ICACHE_INDEX_WIDTH-1:0] lookup_index,
    input  logic [`ICACHE_ASSOC-1:0]       way_valid,
    output logic [`ICACHE_WAY_WIDTH-1:0]   victim_way
);

    // bit names the way to evict next
    logic [`ICACHE_NUM_SETS-1:0] plru_bits;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            plru_bits <= '0;
        end else if (touch_valid) begin
            // point away from the way just used
            plru_bits[touch_index] <= ~touch_way;
        end
    end

    // empty way first, lowest one wins
    always_comb begin
        victim_way = plru_bits[lookup_index];
        for (int way = `ICACHE_ASSOC - 1; way >= 0; way--) begin
            if (~way_valid[way]) begin
                victim_way = `ICACHE_WAY_WIDTH'(way);
            end
        end
    end

endmodule

// ==== icache/icache_miss_reg.sv ====
// ------------------------------
// miss register, L2 request and
// block fill into the arrays
// ------------------------------

`include "icache_cfg.svh"

module icache_miss_reg (
    input  logic                            CLK,
    input  logic                            nRST,

    // core feedback in the response cycle
    input  logic                            core_resp_valid,
    input  logic [`ICACHE_INDEX_WIDTH-1:0]  core_resp_index,
    input  logic                            core_resp_miss_valid,
    input  logic [`ICACHE_TAG_WIDTH-1:0]    core_resp_miss_tag,
    input  logic [`ICACHE_WAY_WIDTH-1:0]    victim_way,

    // L2 request, ready-valid
    output logic                            l2_req_valid,
    output addr_pkg::block_addr_t           l2_req_addr,
    input  logic                            l2_req_ready,

    // L2 response, cannot be stalled
    input  logic                            l2_resp_valid,
    input  addr_pkg::block_addr_t           l2_resp_addr,
    input  logic [`ICACHE_BLOCK_BITS-1:0]   l2_resp_data,

    // array write ports
    output logic [`ICACHE_ASSOC-1:0]        tag_wen,
    output logic [`ICACHE_INDEX_WIDTH-1:0]  tag_windex,
    output icache_pkg::tag_set_t            tag_wdata,
    output logic [`ICACHE_ASSOC-1:0]        data_wen,
    output addr_pkg::fetch_addr_t           data_windex,
    output icache_pkg::fetch_set_t          data_wdata,

    output icache_pkg::fill_t               fill
);

    icache_pkg::miss_ctrl_t miss_q, miss_d;
    icache_pkg::block_buf_t buf_q, buf_d;

    logic last_chunk;
    logic same_miss;
    logic resp_match;

    assign last_chunk = (miss_q.blkoff == '1);

    // ------------------------------
    // next state
    // ------------------------------

    always_comb begin
        miss_d = miss_q;
        miss_d.delay = 1'b0;
        buf_d = buf_q;

        same_miss = core_resp_valid & miss_q.valid
            & (core_resp_index == miss_q.index)
            & (core_resp_miss_tag == miss_q.tag);

        // a response for an older miss is dropped here
        resp_match = l2_resp_valid
            & (l2_resp_addr.fields.index == miss_q.index)
            & (l2_resp_addr.fields.tag == miss_q.tag);

        // fill still has chunks left
        if (miss_q.valid & miss_q.data_valid & ~last_chunk) begin
            miss_d.blkoff = miss_q.blkoff + 1'b1;
        end
        // new miss replaces whatever is waiting
        else if (core_resp_miss_valid & ~same_miss) begin
            miss_d.valid = 1'b1;
            miss_d.requested = 1'b0;
            miss_d.index = core_resp_index;
            miss_d.tag = core_resp_miss_tag;
            miss_d.way = victim_way;
            miss_d.data_valid = 1'b0;
            miss_d.blkoff = '0;
        end
        // last chunk goes out this cycle
        else if (miss_q.valid & miss_q.data_valid) begin
            miss_d.data_valid = 1'b0;
            miss_d.delay = 1'b1;
        end
        // bypass held one more cycle, then free
        else if (miss_q.valid & miss_q.delay) begin
            miss_d.valid = 1'b0;
        end
        else if (miss_q.valid) begin
            if (resp_match) begin
                miss_d.requested = 1'b1;
                miss_d.data_valid = 1'b1;
                buf_d = l2_resp_data;
            end else if (~miss_q.requested & l2_req_ready) begin
                miss_d.requested = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            miss_q <= '0;
        end else begin
            miss_q <= miss_d;
        end
    end

    always_ff @(posedge CLK) begin
        buf_q <= buf_d;
    end

    // ------------------------------
    // outputs
    // ------------------------------

    always_comb begin
        l2_req_valid = miss_q.valid & ~miss_q.requested;
        l2_req_addr.fields.tag = miss_q.tag;
        l2_req_addr.fields.index = miss_q.index;

        // only the victim way is enabled, the data is the same for all
        tag_wen = '0;
        data_wen = '0;
        if (miss_q.valid & miss_q.data_valid) begin
            tag_wen[miss_q.way] = 1'b1;
            data_wen[miss_q.way] = 1'b1;
        end
        tag_windex = miss_q.index;
        data_windex.index = miss_q.index;
        data_windex.blkoff = miss_q.blkoff;
        for (int way = 0; way < `ICACHE_ASSOC; way++) begin
            // entry stays invalid until the last chunk lands
            tag_wdata[way].valid = last_chunk;
            tag_wdata[way].tag = miss_q.tag;
            data_wdata[way] = buf_q[miss_q.blkoff];
        end

        fill.active = miss_q.valid & (miss_q.data_valid | miss_q.delay);
        fill.index = miss_q.index;
        fill.tag = miss_q.tag;
        fill.way = miss_q.way;
        fill.buffer = buf_q;
    end

endmodule

// ==== icache/icache_resp.sv ====
// ------------------------------
// response stage, array read out
// with fill bypass
// ------------------------------

`include "icache_cfg.svh"

module icache_resp (
    input  logic                                              CLK,
    input  logic                                              nRST,

    input  logic                                              core_req_valid,
    input  logic [`ICACHE_INDEX_WIDTH-1:0]                    core_req_index,
    input  logic [`ICACHE_BLKOFF_WIDTH-1:0]                   core_req_blkoff,

    input  icache_pkg::tag_set_t                              tag_rdata,
    input  icache_pkg::fetch_set_t                            data_rdata,
    input  icache_pkg::fill_t                                 fill,

    output logic [`ICACHE_ASSOC-1:0]                          core_resp_valid_by_way,
    output logic [`ICACHE_ASSOC-1:0][`ICACHE_TAG_WIDTH-1:0]   core_resp_tag_by_way,
    output logic [`ICACHE_ASSOC-1:0][`ICACHE_FETCH_BITS-1:0]  core_resp_instr_by_way,

    output logic                                              core_resp_valid,
    output logic [`ICACHE_INDEX_WIDTH-1:0]                    core_resp_index
);

    logic [`ICACHE_BLKOFF_WIDTH-1:0] core_resp_blkoff;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            core_resp_valid <= 1'b0;
            core_resp_index <= '0;
            core_resp_blkoff <= '0;
        end else begin
            core_resp_valid <= core_req_valid;
            core_resp_index <= core_req_index;
            core_resp_blkoff <= core_req_blkoff;
        end
    end

    always_comb begin
        for (int way = 0; way < `ICACHE_ASSOC; way++) begin
            core_resp_valid_by_way[way] = core_resp_valid & tag_rdata[way].valid;
            core_resp_tag_by_way[way] = tag_rdata[way].tag;
            core_resp_instr_by_way[way] = data_rdata[way];
        end

        // set being filled, the array may still be stale so show the buffer
        if (core_resp_valid & fill.active & (fill.index == core_resp_index)) begin
            core_resp_valid_by_way[fill.way] = 1'b1;
            core_resp_tag_by_way[fill.way] = fill.tag;
            core_resp_instr_by_way[fill.way] = fill.buffer[core_resp_blkoff];
        end
    end

endmodule

// ==== icache/icache.sv ====
// ------------------------------
// blocking 2-way L1 icache
// ------------------------------

`include "icache_cfg.svh"

module icache (
    input  logic                                              CLK,
    input  logic                                              nRST,

    // core request
    input  logic                                              core_req_valid,
    input  logic [`ICACHE_INDEX_WIDTH-1:0]                    core_req_index,
    input  logic [`ICACHE_BLKOFF_WIDTH-1:0]                   core_req_blkoff,

    // response to the core, one cycle later
    output logic [`ICACHE_ASSOC-1:0]                          core_resp_valid_by_way,
    output logic [`ICACHE_ASSOC-1:0][`ICACHE_TAG_WIDTH-1:0]   core_resp_tag_by_way,
    output logic [`ICACHE_ASSOC-1:0][`ICACHE_FETCH_BITS-1:0]  core_resp_instr_by_way,

    // core feedback, same cycle as the response
    input  logic                                              core_resp_hit_valid,
    input  logic [`ICACHE_WAY_WIDTH-1:0]                      core_resp_hit_way,
    input  logic                                              core_resp_miss_valid,
    input  logic [`ICACHE_TAG_WIDTH-1:0]                      core_resp_miss_tag,

    // L2
    output logic                                              l2_req_valid,
    output logic [`BLOCK_ADDR_WIDTH-1:0]                      l2_req_addr,
    input  logic                                              l2_req_ready,
    input  logic                                              l2_resp_valid,
    input  logic [`BLOCK_ADDR_WIDTH-1:0]                      l2_resp_addr,
    input  logic [`ICACHE_BLOCK_BITS-1:0]                     l2_resp_data
);

    logic                           core_resp_valid;
    logic [`ICACHE_INDEX_WIDTH-1:0] core_resp_index;
    logic [`ICACHE_WAY_WIDTH-1:0]   victim_way;

    icache_pkg::tag_set_t           tag_rdata;
    icache_pkg::fetch_set_t         data_rdata;
    addr_pkg::fetch_addr_t          data_rindex;

    logic [`ICACHE_ASSOC-1:0]       tag_wen;
    logic [`ICACHE_INDEX_WIDTH-1:0] tag_windex;
    icache_pkg::tag_set_t           tag_wdata;
    logic [`ICACHE_ASSOC-1:0]       data_wen;
    addr_pkg::fetch_addr_t          data_windex;
    icache_pkg::fetch_set_t         data_wdata;

    icache_pkg::fill_t              fill;
    addr_pkg::block_addr_t          req_addr;
    addr_pkg::block_addr_t          resp_addr;

    assign data_rindex.index = core_req_index;
    assign data_rindex.blkoff = core_req_blkoff;
    assign l2_req_addr = req_addr.flat;
    assign resp_addr.flat = l2_resp_addr;

    // ------------------------------
    // arrays
    // ------------------------------

    bram_1r1w #(
        .LANE_BITS($bits(icache_pkg::tag_entry_t)),
        .LANES(`ICACHE_ASSOC),
        .DEPTH(`ICACHE_NUM_SETS)
    ) tag_bram (
        .CLK(CLK),
        .nRST(nRST),
        .ren(core_req_valid),
        .rindex(core_req_index),
        .rdata(tag_rdata),
        .wen(tag_wen),
        .windex(tag_windex),
        .wdata(tag_wdata)
    );

    // one row per fetch chunk
    bram_1r1w #(
        .LANE_BITS(`ICACHE_FETCH_BITS),
        .LANES(`ICACHE_ASSOC),
        .DEPTH(`ICACHE_NUM_SETS * (2 ** `ICACHE_BLKOFF_WIDTH))
    ) data_bram (
        .CLK(CLK),
        .nRST(nRST),
        .ren(core_req_valid),
        .rindex(data_rindex),
        .rdata(data_rdata),
        .wen(data_wen),
        .windex(data_windex),
        .wdata(data_wdata)
    );

    // ------------------------------
    // control
    // ------------------------------

    way_plru u_plru (
        .CLK(CLK),
        .nRST(nRST),
        .touch_valid(core_resp_hit_valid),
        .touch_index(core_resp_index),
        .touch_way(core_resp_hit_way),
        .lookup_index(core_resp_index),
        .way_valid(core_resp_valid_by_way),
        .victim_way(victim_way)
    );

    icache_miss_reg u_miss (
        .CLK(CLK),
        .nRST(nRST),
        .core_resp_valid(core_resp_valid),
        .core_resp_index(core_resp_index),
        .core_resp_miss_valid(core_resp_miss_valid),
        .core_resp_miss_tag(core_resp_miss_tag),
        .victim_way(victim_way),
        .l2_req_valid(l2_req_valid),
        .l2_req_addr(req_addr),
        .l2_req_ready(l2_req_ready),
        .l2_resp_valid(l2_resp_valid),
        .l2_resp_addr(resp_addr),
        .l2_resp_data(l2_resp_data),
        .tag_wen(tag_wen),
        .tag_windex(tag_windex),
        .tag_wdata(tag_wdata),
        .data_wen(data_wen),
        .data_windex(data_windex),
        .data_wdata(data_wdata),
        .fill(fill)
    );

    icache_resp u_resp (
        .CLK(CLK),
        .nRST(nRST),
        .core_req_valid(core_req_valid),
        .core_req_index(core_req_index),
        .core_req_blkoff(core_req_blkoff),
        .tag_rdata(tag_rdata),
        .data_rdata(data_rdata),
        .fill(fill),
        .core_resp_valid_by_way(core_resp_valid_by_way),
        .core_resp_tag_by_way(core_resp_tag_by_way),
        .core_resp_instr_by_way(core_resp_instr_by_way),
        .core_resp_valid(core_resp_valid),
        .core_resp_index(core_resp_index)
    );

endmodule

// ==== tests/icache_tb_tasks.svh ====
// ------------------------------
// icache testbench helpers and
// directed tests
// ------------------------------

`ifndef ICACHE_TB_TASKS_SVH
`define ICACHE_TB_TASKS_SVH

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hb400;
        end
        return next;
    endfunction

    // one LFSR step per bit
    task automatic random_block(output logic [`ICACHE_BLOCK_BITS-1:0] blk);
        for (int i = 0; i < `ICACHE_BLOCK_BITS; i++) begin
            blk[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // chunk 0 sits in the low bits of the block
    function automatic logic [`ICACHE_FETCH_BITS-1:0] block_chunk(
        input logic [`ICACHE_BLOCK_BITS-1:0] blk,
        input int                            off
    );
        return blk[off * `ICACHE_FETCH_BITS +: `ICACHE_FETCH_BITS];
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        @(negedge CLK);
    endtask

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(
        input string                         name,
        input logic [`ICACHE_BLOCK_BITS-1:0] actual,
        input logic [`ICACHE_BLOCK_BITS-1:0] expected
    );
        if (actual !== expected) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    // ------------------------------
    // core model
    // ------------------------------

    // request the chunk and look for the tag among the valid ways
    // feedback stays driven until the next fetch or end_fetch
    task automatic fetch(
        input logic [`ICACHE_INDEX_WIDTH-1:0]  index,
        input logic [`ICACHE_BLKOFF_WIDTH-1:0] blkoff,
        input logic [`ICACHE_TAG_WIDTH-1:0]    tag,
        input logic                            exp_hit,
        input logic [`ICACHE_WAY_WIDTH-1:0]    exp_way,
        input logic [`ICACHE_FETCH_BITS-1:0]   exp_data,
        input logic                            send_fb
    );
        logic                         hit;
        logic [`ICACHE_WAY_WIDTH-1:0] way;
        core_req_valid = 1'b1;
        core_req_index = index;
        core_req_blkoff = blkoff;
        next_cycle();
        core_req_valid = 1'b0;
        core_resp_hit_valid = 1'b0;
        core_resp_miss_valid = 1'b0;
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < `ICACHE_ASSOC; w++) begin
            if (core_resp_valid_by_way[w] && core_resp_tag_by_way[w] == tag) begin
                hit = 1'b1;
                way = `ICACHE_WAY_WIDTH'(w);
            end
        end
        check_value("hit", hit, exp_hit);
        if (hit) begin
            check_value("core_resp_hit_way", way, exp_way);
            check_value("core_resp_instr_by_way", core_resp_instr_by_way[way], exp_data);
        end
        if (send_fb && hit) begin
            core_resp_hit_valid = 1'b1;
            core_resp_hit_way = way;
        end else if (send_fb) begin
            core_resp_miss_valid = 1'b1;
            core_resp_miss_tag = tag;
        end
    endtask

    task automatic end_fetch();
        next_cycle();
        core_resp_hit_valid = 1'b0;
        core_resp_miss_valid = 1'b0;
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------

    task automatic check_reset_state();
        for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
            fetch(`ICACHE_INDEX_WIDTH'(s), `ICACHE_BLKOFF_WIDTH'(s), '0, 1'b0, '0, '0, 1'b0);
            check_value("core_resp_valid_by_way", core_resp_valid_by_way, '0);
            check_value("l2_req_valid", l2_req_valid, 1'b0);
        end
        end_fetch();
        check_value("l2_req_valid", l2_req_valid, 1'b0);
    endtask

    task automatic cold_miss_request();
        random_block(blk_a);
        fetch(SET_A, 1'b0, TAG_A, 1'b0, '0, '0, 1'b1);
        end_fetch();
        // up in the cycle after the miss feedback
        check_value("l2_req_valid", l2_req_valid, 1'b1);
        accept_l2_req({TAG_A, SET_A}, 4);
    endtask

    task automatic fill_and_hit();
        send_l2_resp(3, {TAG_A, SET_A}, blk_a);
        // first two answered from the fill buffer
        // no hit feedback so the PLRU bit of the set stays at way 0
        fetch(SET_A, 1'b0, TAG_A, 1'b1, 1'b0, block_chunk(blk_a, 0), 1'b0);
        fetch(SET_A, 1'b1, TAG_A, 1'b1, 1'b0, block_chunk(blk_a, 1), 1'b0);
        fetch(SET_A, 1'b0, TAG_A, 1'b1, 1'b0, block_chunk(blk_a, 0), 1'b0);
        fetch(SET_A, 1'b1, TAG_A, 1'b1, 1'b0, block_chunk(blk_a, 1), 1'b0);
        end_fetch();
    endtask

    task automatic replace_by_plru();
        random_block(blk_b);
        random_block(blk_c);
        // PLRU names way 0 but way 1 is empty and goes first
        fetch(SET_A, 1'b0, TAG_B, 1'b0, '0, '0, 1'b1);
        end_fetch();
        accept_l2_req({TAG_B, SET_A}, 0);
        send_l2_resp(2, {TAG_B, SET_A}, blk_b);
        repeat (4) next_cycle();
        fetch(SET_A, 1'b1, TAG_B, 1'b1, 1'b1, block_chunk(blk_b, 1), 1'b1);
        fetch(SET_A, 1'b0, TAG_A, 1'b1, 1'b0, block_chunk(blk_a, 0), 1'b1);
        // set full and the last hit was way 0 so way 1 goes
        fetch(SET_A, 1'b1, TAG_C, 1'b0, '0, '0, 1'b1);
        end_fetch();
        accept_l2_req({TAG_C, SET_A}, 1);
        send_l2_resp(1, {TAG_C, SET_A}, blk_c);
        repeat (4) next_cycle();
        fetch(SET_A, 1'b0, TAG_C, 1'b1, 1'b1, block_chunk(blk_c, 0), 1'b1);
        fetch(SET_A, 1'b1, TAG_A, 1'b1, 1'b0, block_chunk(blk_a, 1), 1'b1);
        fetch(SET_A, 1'b0, TAG_B, 1'b0, '0, '0, 1'b0);
        end_fetch();
    endtask

    task automatic ignore_stale_response();
        random_block(blk_d);
        random_block(blk_stale);
        fetch(SET_D, 1'b0, TAG_D, 1'b0, '0, '0, 1'b1);
        end_fetch();
        accept_l2_req({TAG_D, SET_D}, 1);
        send_l2_resp(1, {TAG_STALE, SET_D}, blk_stale);
        repeat (4) next_cycle();
        fetch(SET_D, 1'b0, TAG_D, 1'b0, '0, '0, 1'b0);
        check_value("core_resp_valid_by_way", core_resp_valid_by_way, '0);
        end_fetch();
        check_value("l2_req_valid", l2_req_valid, 1'b0);
        send_l2_resp(2, {TAG_D, SET_D}, blk_d);
        repeat (4) next_cycle();
        fetch(SET_D, 1'b1, TAG_D, 1'b1, 1'b0, block_chunk(blk_d, 1), 1'b1);
        fetch(SET_D, 1'b0, TAG_D, 1'b1, 1'b0, block_chunk(blk_d, 0), 1'b1);
        end_fetch();
    endtask

`endif

// ==== tests/icache_tb.sv ====
// ------------------------------
// icache testbench, drives the
// core side and models L2
// ------------------------------

`include "icache_cfg.svh"

module icache_tb;

    localparam int TIMEOUT_CYCLES = 50;

    // test addresses, sets A and D start out empty
    localparam logic [`ICACHE_INDEX_WIDTH-1:0] SET_A = 4'd5;
    localparam logic [`ICACHE_INDEX_WIDTH-1:0] SET_D = 4'd9;
    localparam logic [`ICACHE_TAG_WIDTH-1:0]   TAG_A = 10'h2a3;
    localparam logic [`ICACHE_TAG_WIDTH-1:0]   TAG_B = 10'h155;
    localparam logic [`ICACHE_TAG_WIDTH-1:0]   TAG_C = 10'h0f0;
    localparam logic [`ICACHE_TAG_WIDTH-1:0]   TAG_D = 10'h3c7;
    localparam logic [`ICACHE_TAG_WIDTH-1:0]   TAG_STALE = 10'h3c6;

    logic                                             CLK;
    logic                                             nRST;
    logic                                             core_req_valid;
    logic [`ICACHE_INDEX_WIDTH-1:0]                   core_req_index;
    logic [`ICACHE_BLKOFF_WIDTH-1:0]                  core_req_blkoff;
    logic [`ICACHE_ASSOC-1:0]                         core_resp_valid_by_way;
    logic [`ICACHE_ASSOC-1:0][`ICACHE_TAG_WIDTH-1:0]  core_resp_tag_by_way;
    logic [`ICACHE_ASSOC-1:0][`ICACHE_FETCH_BITS-1:0] core_resp_instr_by_way;
    logic                                             core_resp_hit_valid;
    logic [`ICACHE_WAY_WIDTH-1:0]                     core_resp_hit_way;
    logic                                             core_resp_miss_valid;
    logic [`ICACHE_TAG_WIDTH-1:0]                     core_resp_miss_tag;
    logic                                             l2_req_valid;
    logic [`BLOCK_ADDR_WIDTH-1:0]                     l2_req_addr;
    logic                                             l2_req_ready;
    logic                                             l2_resp_valid;
    logic [`BLOCK_ADDR_WIDTH-1:0]                     l2_resp_addr;
    logic [`ICACHE_BLOCK_BITS-1:0]                    l2_resp_data;

    logic [15:0]                   lfsr_state;
    logic [`ICACHE_BLOCK_BITS-1:0] blk_a, blk_b, blk_c, blk_d, blk_stale;

    icache DUT (
        .CLK(CLK),
        .nRST(nRST),
        .core_req_valid(core_req_valid),
        .core_req_index(core_req_index),
        .core_req_blkoff(core_req_blkoff),
        .core_resp_valid_by_way(core_resp_valid_by_way),
        .core_resp_tag_by_way(core_resp_tag_by_way),
        .core_resp_instr_by_way(core_resp_instr_by_way),
        .core_resp_hit_valid(core_resp_hit_valid),
        .core_resp_hit_way(core_resp_hit_way),
        .core_resp_miss_valid(core_resp_miss_valid),
        .core_resp_miss_tag(core_resp_miss_tag),
        .l2_req_valid(l2_req_valid),
        .l2_req_addr(l2_req_addr),
        .l2_req_ready(l2_req_ready),
        .l2_resp_valid(l2_resp_valid),
        .l2_resp_addr(l2_resp_addr),
        .l2_resp_data(l2_resp_data)
    );

    always #2 CLK = ~CLK;

    // ------------------------------
    // L2 model
    // ------------------------------

    // wait for the request, keep ready low for a while, then take it
    task automatic accept_l2_req(
        input logic [`BLOCK_ADDR_WIDTH-1:0] addr,
        input int                           ready_delay
    );
        int cycles;
        cycles = 0;
        while (!l2_req_valid && cycles < TIMEOUT_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (!l2_req_valid) begin
            $display("timed out waiting for l2_req_valid to rise");
            abort_run();
        end
        check_value("l2_req_addr", l2_req_addr, addr);
        repeat (ready_delay) begin
            next_cycle();
            check_value("l2_req_valid", l2_req_valid, 1'b1);
            check_value("l2_req_addr", l2_req_addr, addr);
        end
        l2_req_ready = 1'b1;
        next_cycle();
        l2_req_ready = 1'b0;
        // request gone after the accepting cycle
        check_value("l2_req_valid", l2_req_valid, 1'b0);
    endtask

    // one-cycle response, cannot be stalled
    task automatic send_l2_resp(
        input int                            delay,
        input logic [`BLOCK_ADDR_WIDTH-1:0]  addr,
        input logic [`ICACHE_BLOCK_BITS-1:0] data
    );
        repeat (delay) next_cycle();
        l2_resp_valid = 1'b1;
        l2_resp_addr = addr;
        l2_resp_data = data;
        next_cycle();
        l2_resp_valid = 1'b0;
    endtask

    `include "icache_tb_tasks.svh"

    // ------------------------------
    // test sequence
    // ------------------------------

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        core_req_valid = 1'b0;
        core_req_index = '0;
        core_req_blkoff = '0;
        core_resp_hit_valid = 1'b0;
        core_resp_hit_way = '0;
        core_resp_miss_valid = 1'b0;
        core_resp_miss_tag = '0;
        l2_req_ready = 1'b0;
        l2_resp_valid = 1'b0;
        l2_resp_addr = '0;
        l2_resp_data = '0;
        lfsr_state = 16'd58831;

        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        check_reset_state();
        cold_miss_request();
        fill_and_hit();
        replace_by_plru();
        ignore_stale_response();

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
+incdir+tests
common/addr_pkg.sv
common/icache_pkg.sv
logic/bram_1r1w.sv
logic/way_plru.sv
icache/icache_miss_reg.sv
icache/icache_resp.sv
icache/icache.sv
tests/icache_tb.sv
